// ==== include/rsqrt_defs.svh ====
`ifndef RSQRT_DEFS_SVH
`define RSQRT_DEFS_SVH

// fixed-point datapath is Q2.26
`define RSQRT_FIX_W 28
`define RSQRT_FRAC 26

// seed table is addressed by the top bits of a
`define RSQRT_LUT_BITS 8

// newton iterations and their cost
`define RSQRT_NEWTON_STEPS 2
`define RSQRT_STEP_LAT 7

// classify 1, seed 1, steps 2 x 7, pack 1
`define RSQRT_LATENCY 17

// 3.0 in Q2.26
`define RSQRT_THREE 28'hC000000

// canonical quiet NaN
`define RSQRT_QNAN 32'h7FC00000

// quiet bit inside the 23-bit mantissa
`define RSQRT_QUIET_BIT 22

`endif

// ==== hdl/rsqrt_pkg.sv ====
package rsqrt_pkg;

    // IEEE-754 single precision
    typedef struct packed {
        logic        sign;
        logic [7:0]  exponent;
        logic [22:0] mantissa;
    } fp32_t;

    // operand class after decode
    typedef enum logic [2:0] {
        CLASS_NORMAL,
        CLASS_ZERO,
        CLASS_DENORM,
        CLASS_INF,
        CLASS_QNAN,
        CLASS_SNAN
    } fp_class_e;

    // sideband carried next to every operand through the pipe
    typedef struct packed {
        logic [7:0] exponent;
        logic       mant_is_one;
        logic       special;
        fp32_t      special_result;
        logic       invalid;
        logic       div_by_zero;
    } rsqrt_side_t;

endpackage

// ==== hdl/rsqrt_classify.sv ====
`include "rsqrt_defs.svh"

module rsqrt_classify (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  rsqrt_pkg::fp32_t          operand,
    output logic                      valid,
    output logic [`RSQRT_FIX_W-1:0]   a,
    output rsqrt_pkg::rsqrt_side_t    side
);
    rsqrt_pkg::fp_class_e   op_class;
    logic                   mant_zero;
    logic                   exp_even;
    logic [8:0]             exp_diff;
    logic [`RSQRT_FIX_W-1:0] a_next;
    rsqrt_pkg::rsqrt_side_t side_next;

    // operand decode
    always_comb begin
        mant_zero = (operand.mantissa == '0);
        if (operand.exponent == 8'hff) begin
            if (mant_zero) begin
                op_class = rsqrt_pkg::CLASS_INF;
            end else if (operand.mantissa[`RSQRT_QUIET_BIT]) begin
                op_class = rsqrt_pkg::CLASS_QNAN;
            end else begin
                op_class = rsqrt_pkg::CLASS_SNAN;
            end
        end else if (operand.exponent == 8'h00) begin
            op_class = mant_zero ? rsqrt_pkg::CLASS_ZERO : rsqrt_pkg::CLASS_DENORM;
        end else begin
            op_class = rsqrt_pkg::CLASS_NORMAL;
        end
    end

    always_comb begin
        // an even biased exponent means an odd true exponent, so fold a factor 2 into a
        exp_even = ~operand.exponent[0];
        side_next = '0;
        if (exp_even) begin
            exp_diff = 9'd382 - {1'b0, operand.exponent};
            a_next = {1'b1, operand.mantissa, 4'b0000};
            side_next.exponent = exp_diff[8:1];
        end else begin
            exp_diff = 9'd381 - {1'b0, operand.exponent};
            a_next = {2'b01, operand.mantissa, 3'b000};
            side_next.exponent = exp_diff[8:1] + {7'd0, mant_zero};
        end
        // a is exactly 1.0 here
        side_next.mant_is_one = ~exp_even & mant_zero;

        case (op_class)
            rsqrt_pkg::CLASS_QNAN: begin
                side_next.special = 1'b1;
                side_next.special_result = operand;
            end
            rsqrt_pkg::CLASS_SNAN: begin
                side_next.special = 1'b1;
                side_next.special_result = operand | (32'd1 << `RSQRT_QUIET_BIT);
                side_next.invalid = 1'b1;
            end
            rsqrt_pkg::CLASS_ZERO, rsqrt_pkg::CLASS_DENORM: begin
                // denormals are flushed and treated as zero
                side_next.special = 1'b1;
                side_next.special_result = {operand.sign, 8'hff, 23'd0};
                side_next.div_by_zero = 1'b1;
            end
            default: begin
                if (operand.sign) begin
                    side_next.special = 1'b1;
                    side_next.special_result = `RSQRT_QNAN;
                    side_next.invalid = 1'b1;
                end else if (op_class == rsqrt_pkg::CLASS_INF) begin
                    side_next.special = 1'b1;
                    side_next.special_result = '0;
                end
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        a <= a_next;
        side <= side_next;
    end

endmodule

// ==== hdl/rsqrt_seed_lut.sv ====
`include "rsqrt_defs.svh"

module rsqrt_seed_lut (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [`RSQRT_FIX_W-1:0]   a_in,
    input  rsqrt_pkg::rsqrt_side_t    side_in,
    output logic                      valid,
    output logic [`RSQRT_FIX_W-1:0]   x,
    output logic [`RSQRT_FIX_W-1:0]   a,
    output rsqrt_pkg::rsqrt_side_t    side
);
    // floor(2^26 / sqrt((k + 0.5) / 64)) equals floor(sqrt(2^59 / (2k + 1)))
    function automatic logic [`RSQRT_FIX_W-1:0] seed_value(input int k);
        logic [63:0] n;
        logic [63:0] root;
        logic [63:0] trial;
        n = (64'd1 << 59) / (2 * k + 1);
        root = '0;
        for (int i = 31; i >= 0; i--) begin
            trial = root | (64'd1 << i);
            if (trial * trial <= n) begin
                root = trial;
            end
        end
        return (k < 64) ? '0 : root[`RSQRT_FIX_W-1:0];
    endfunction

    logic [`RSQRT_FIX_W-1:0] seed_rom [1 << `RSQRT_LUT_BITS];

    for (genvar k = 0; k < (1 << `RSQRT_LUT_BITS); k++) begin : g_rom
        assign seed_rom[k] = seed_value(k);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        x <= seed_rom[a_in[`RSQRT_FIX_W-1 -: `RSQRT_LUT_BITS]];
        a <= a_in;
        side <= side_in;
    end

endmodule

// ==== hdl/mult_pipe.sv ====
`include "rsqrt_defs.svh"

module mult_pipe (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`RSQRT_FIX_W-1:0] in1,
    input  logic [`RSQRT_FIX_W-1:0] in2,
    output logic [`RSQRT_FIX_W-1:0] product
);
    logic [`RSQRT_FIX_W-1:0]   in1_r;
    logic [`RSQRT_FIX_W-1:0]   in2_r;
    logic [2*`RSQRT_FIX_W-1:0] full_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in1_r <= '0;
            in2_r <= '0;
            full_r <= '0;
        end else begin
            in1_r <= in1;
            in2_r <= in2;
            full_r <= in1_r * in2_r;
        end
    end

    // Q4.52 back to Q2.26, top two integer bits dropped
    assign product = full_r[2*`RSQRT_FRAC+1:`RSQRT_FRAC];

endmodule

// ==== hdl/newton_step.sv ====
`include "rsqrt_defs.svh"

module newton_step (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [`RSQRT_FIX_W-1:0]   x_in,
    input  logic [`RSQRT_FIX_W-1:0]   a_in,
    input  rsqrt_pkg::rsqrt_side_t    side_in,
    output logic                      valid,
    output logic [`RSQRT_FIX_W-1:0]   x,
    output logic [`RSQRT_FIX_W-1:0]   a,
    output rsqrt_pkg::rsqrt_side_t    side
);
    // one iteration x' = x * (3 - a * x^2) / 2
    // cycle 0..2 square, 2..4 times a, 4..5 subtract, 5..7 final product

    logic                   valid_d [`RSQRT_STEP_LAT];
    logic [`RSQRT_FIX_W-1:0] a_d    [`RSQRT_STEP_LAT];
    rsqrt_pkg::rsqrt_side_t side_d  [`RSQRT_STEP_LAT];
    // x is only needed until the last multiply starts
    logic [`RSQRT_FIX_W-1:0] x_d    [`RSQRT_STEP_LAT-2];

    logic [`RSQRT_FIX_W-1:0] w;
    logic [`RSQRT_FIX_W-1:0] y;
    logic [`RSQRT_FIX_W-1:0] z;
    logic [`RSQRT_FIX_W-1:0] x_half;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RSQRT_STEP_LAT; i++) begin
                valid_d[i] <= 1'b0;
            end
        end else begin
            valid_d[0] <= in_valid;
            for (int i = 1; i < `RSQRT_STEP_LAT; i++) begin
                valid_d[i] <= valid_d[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        a_d[0] <= a_in;
        side_d[0] <= side_in;
        x_d[0] <= x_in;
        for (int i = 1; i < `RSQRT_STEP_LAT; i++) begin
            a_d[i] <= a_d[i-1];
            side_d[i] <= side_d[i-1];
        end
        for (int i = 1; i < `RSQRT_STEP_LAT - 2; i++) begin
            x_d[i] <= x_d[i-1];
        end
        // wraps modulo 2^28 when a*x^2 overshoots 3
        z <= `RSQRT_THREE - y;
    end

    // w = x * x
    mult_pipe square_i (
        .clk     (clk),
        .rst     (rst),
        .in1     (x_in),
        .in2     (x_in),
        .product (w)
    );

    // y = a * w, a taken two cycles late to meet w
    mult_pipe scale_i (
        .clk     (clk),
        .rst     (rst),
        .in1     (a_d[1]),
        .in2     (w),
        .product (y)
    );

    // x delayed five cycles lines up with the registered z
    assign x_half = x_d[`RSQRT_STEP_LAT-3] >> 1;

    mult_pipe update_i (
        .clk     (clk),
        .rst     (rst),
        .in1     (x_half),
        .in2     (z),
        .product (x)
    );

    assign valid = valid_d[`RSQRT_STEP_LAT-1];
    assign a = a_d[`RSQRT_STEP_LAT-1];
    assign side = side_d[`RSQRT_STEP_LAT-1];

endmodule

// ==== hdl/rsqrt_round_pack.sv ====
`include "rsqrt_defs.svh"

module rsqrt_round_pack (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    input  logic [`RSQRT_FIX_W-1:0]   x_in,
    input  rsqrt_pkg::rsqrt_side_t    side_in,
    output logic                      out_valid,
    output rsqrt_pkg::fp32_t          result,
    output logic                      invalid,
    output logic                      division_by_zero,
    output logic                      inexact
);
    logic             below_one;
    logic [22:0]      mant;
    logic             guard;
    logic             round_bit;
    logic             sticky;
    logic             round_up;
    logic [23:0]      mant_rnd;
    logic [7:0]       exp_norm;
    logic             grs;
    rsqrt_pkg::fp32_t packed_res;

    always_comb begin
        // side exponent assumes x in [1,2); one less when the lead bit sits at 0.5
        below_one = ~x_in[`RSQRT_FRAC];
        if (below_one) begin
            mant = x_in[`RSQRT_FRAC-2 -: 23];
            guard = x_in[1];
            round_bit = x_in[0];
            sticky = 1'b0;
        end else begin
            mant = x_in[`RSQRT_FRAC-1 -: 23];
            guard = x_in[2];
            round_bit = x_in[1];
            sticky = x_in[0];
        end
        grs = guard | round_bit | sticky;

        // nearest even
        round_up = guard & (round_bit | sticky | mant[0]);
        mant_rnd = {1'b0, mant} + {23'd0, round_up};
        exp_norm = side_in.exponent - {7'd0, below_one};

        if (side_in.special) begin
            packed_res = side_in.special_result;
        end else if (side_in.mant_is_one) begin
            // exact power of two, the stored exponent already includes the round carry
            packed_res = {1'b0, side_in.exponent - 8'd1, 23'd0};
        end else begin
            // a mantissa carry leaves mant_rnd[22:0] at zero
            packed_res = {1'b0, exp_norm + {7'd0, mant_rnd[23]}, mant_rnd[22:0]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            result <= '0;
            invalid <= 1'b0;
            division_by_zero <= 1'b0;
            inexact <= 1'b0;
        end else begin
            out_valid <= in_valid;
            // flags only accompany a valid result
            invalid <= in_valid & side_in.invalid;
            division_by_zero <= in_valid & side_in.div_by_zero;
            inexact <= in_valid & ~side_in.special & ~side_in.mant_is_one & grs;
            if (in_valid) begin
                result <= packed_res;
            end
        end
    end

endmodule

// ==== hdl/fp_rsqrt_top.sv ====
`include "rsqrt_defs.svh"

module fp_rsqrt_top (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  rsqrt_pkg::fp32_t operand,
    output logic             out_valid,
    output rsqrt_pkg::fp32_t result,
    output logic             invalid,
    output logic             division_by_zero,
    output logic             inexact
);
    logic                    cls_valid;
    logic [`RSQRT_FIX_W-1:0] cls_a;
    rsqrt_pkg::rsqrt_side_t  cls_side;

    // index 0 is the seed, index i+1 the output of step i
    logic                    stg_valid [`RSQRT_NEWTON_STEPS+1];
    logic [`RSQRT_FIX_W-1:0] stg_x     [`RSQRT_NEWTON_STEPS+1];
    logic [`RSQRT_FIX_W-1:0] stg_a     [`RSQRT_NEWTON_STEPS+1];
    rsqrt_pkg::rsqrt_side_t  stg_side  [`RSQRT_NEWTON_STEPS+1];

    rsqrt_classify classify_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .operand  (operand),
        .valid    (cls_valid),
        .a        (cls_a),
        .side     (cls_side)
    );

    rsqrt_seed_lut seed_i (
        .clk      (clk),
        .rst      (rst),
        .in_valid (cls_valid),
        .a_in     (cls_a),
        .side_in  (cls_side),
        .valid    (stg_valid[0]),
        .x        (stg_x[0]),
        .a        (stg_a[0]),
        .side     (stg_side[0])
    );

    for (genvar i = 0; i < `RSQRT_NEWTON_STEPS; i++) begin : g_step
        newton_step step_i (
            .clk      (clk),
            .rst      (rst),
            .in_valid (stg_valid[i]),
            .x_in     (stg_x[i]),
            .a_in     (stg_a[i]),
            .side_in  (stg_side[i]),
            .valid    (stg_valid[i+1]),
            .x        (stg_x[i+1]),
            .a        (stg_a[i+1]),
            .side     (stg_side[i+1])
        );
    end

    rsqrt_round_pack pack_i (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (stg_valid[`RSQRT_NEWTON_STEPS]),
        .x_in             (stg_x[`RSQRT_NEWTON_STEPS]),
        .side_in          (stg_side[`RSQRT_NEWTON_STEPS]),
        .out_valid        (out_valid),
        .result           (result),
        .invalid          (invalid),
        .division_by_zero (division_by_zero),
        .inexact          (inexact)
    );

endmodule

// ==== test/fp_rsqrt_sva.sv ====
`include "rsqrt_defs.svh"

module fp_rsqrt_sva (
    input logic             clk,
    input logic             rst,
    input logic             in_valid,
    input logic             out_valid,
    input rsqrt_pkg::fp32_t result,
    input logic             invalid,
    input logic             division_by_zero,
    input logic             inexact
);
    // number of failed assertions
    int fail_count = 0;

    // every strobe leaves after the fixed pipeline depth
    latency_a: assert property (@(posedge clk) disable iff (rst)
        in_valid |-> ##`RSQRT_LATENCY out_valid)
        else begin
            fail_count++;
            $error("out_valid missing %0d cycles after in_valid", `RSQRT_LATENCY);
        end

    // and no output strobe appears without a matching input strobe
    no_spurious_a: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> $past(in_valid, `RSQRT_LATENCY))
        else begin
            fail_count++;
            $error("out_valid without in_valid %0d cycles before", `RSQRT_LATENCY);
        end

    // flags only accompany a result
    flags_quiet_a: assert property (@(posedge clk) disable iff (rst)
        !out_valid |-> !(invalid || division_by_zero || inexact))
        else begin
            fail_count++;
            $error("flag raised while out_valid is low");
        end

    // invalid always comes with some NaN
    invalid_nan_a: assert property (@(posedge clk) disable iff (rst)
        invalid |-> (result.exponent == 8'hff && result.mantissa != '0))
        else begin
            fail_count++;
            $error("invalid raised with a result that is not a NaN");
        end

endmodule

// ==== test/tb_fp_rsqrt.sv ====
`include "rsqrt_defs.svh"

module tb_fp_rsqrt;
    localparam int clk_period = 40;
    localparam int reset_cycles = 4;
    localparam int n_directed = 17;
    localparam int n_burst = 256;
    localparam int n_mixed = 400;
    // at most four cycles per operand plus drain and margin
    localparam int watchdog_cycles = reset_cycles + 4 * (n_directed + n_burst + n_mixed)
                                     + `RSQRT_LATENCY + 100;

    logic             clk = 1'b0;
    logic             rst;
    logic             in_valid;
    rsqrt_pkg::fp32_t operand;
    logic             out_valid;
    rsqrt_pkg::fp32_t result;
    logic             invalid;
    logic             division_by_zero;
    logic             inexact;

    integer      seed = 32'h92621c65;
    int          cycle_count = 0;
    // expected word is {result, invalid, division_by_zero, inexact}
    logic [34:0] expected_q [$];
    int          strobe_q [$];

    fp_rsqrt_top fp_rsqrt_top_i (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (in_valid),
        .operand          (operand),
        .out_valid        (out_valid),
        .result           (result),
        .invalid          (invalid),
        .division_by_zero (division_by_zero),
        .inexact          (inexact)
    );

    bind fp_rsqrt_top fp_rsqrt_sva fp_rsqrt_sva_i (
        .clk              (clk),
        .rst              (rst),
        .in_valid         (in_valid),
        .out_valid        (out_valid),
        .result           (result),
        .invalid          (invalid),
        .division_by_zero (division_by_zero),
        .inexact          (inexact)
    );

    always #(clk_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("error at time %0t: %s mismatch, got %h expected %h",
                     $time, what, got, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [34:0] expect_word(input logic [31:0] res, input logic inv,
                                                input logic dbz, input logic inx);
        return {res, inv, dbz, inx};
    endfunction

    // exact floor(2^26 / sqrt((k + 0.5) / 64)), estimated in real and corrected in integers
    function automatic logic [27:0] seed_entry(input int k);
        real         est;
        logic [63:0] r;
        logic [63:0] d;
        logic [63:0] lim;
        if (k < 64) begin
            return '0;
        end
        d = 64'(2 * k + 1);
        lim = 64'd1 << 59;
        est = (2.0 ** 26) / $sqrt((k + 0.5) / 64.0);
        r = 64'($rtoi(est));
        while ((r + 64'd1) * (r + 64'd1) * d <= lim) begin
            r = r + 64'd1;
        end
        while (r * r * d > lim) begin
            r = r - 64'd1;
        end
        return r[27:0];
    endfunction

    // Q2.26 product keeping bits 53..26
    function automatic logic [27:0] fix_mul(input logic [27:0] p, input logic [27:0] q);
        logic [63:0] full;
        full = {36'd0, p} * {36'd0, q};
        return full[53:26];
    endfunction

    function automatic logic [34:0] rsqrt_ref(input logic [31:0] op);
        logic        sign;
        logic [7:0]  e;
        logic [22:0] m;
        logic [27:0] a;
        logic [27:0] x;
        logic [27:0] w;
        logic [27:0] y;
        logic [27:0] z;
        logic [22:0] mant;
        logic [23:0] mant_rnd;
        logic        g;
        logic        r;
        logic        s;
        int          rexp;
        sign = op[31];
        e = op[30:23];
        m = op[22:0];
        if (e == 8'hff && m != '0 && m[22]) begin
            return expect_word(op, 1'b0, 1'b0, 1'b0);
        end
        if (e == 8'hff && m != '0) begin
            return expect_word(op | 32'h0040_0000, 1'b1, 1'b0, 1'b0);
        end
        if (e == 8'h00) begin
            return expect_word({sign, 8'hff, 23'd0}, 1'b0, 1'b1, 1'b0);
        end
        if (sign) begin
            return expect_word(`RSQRT_QNAN, 1'b1, 1'b0, 1'b0);
        end
        if (e == 8'hff) begin
            return expect_word(32'd0, 1'b0, 1'b0, 1'b0);
        end
        // exact power of four gives an exact power of two
        if (e[0] && m == '0) begin
            rexp = (381 - int'(e)) / 2;
            return expect_word({1'b0, rexp[7:0], 23'd0}, 1'b0, 1'b0, 1'b0);
        end
        if (!e[0]) begin
            a = {1'b1, m, 4'd0};
            rexp = (382 - int'(e)) / 2;
        end else begin
            a = {2'b01, m, 3'd0};
            rexp = (381 - int'(e)) / 2;
        end
        x = seed_entry(int'(a[27:20]));
        for (int i = 0; i < `RSQRT_NEWTON_STEPS; i++) begin
            w = fix_mul(x, x);
            y = fix_mul(a, w);
            z = `RSQRT_THREE - y;
            x = fix_mul(x >> 1, z);
        end
        if (x[26]) begin
            mant = x[25:3];
            g = x[2];
            r = x[1];
            s = x[0];
        end else begin
            mant = x[24:2];
            g = x[1];
            r = x[0];
            s = 1'b0;
            rexp = rexp - 1;
        end
        mant_rnd = {1'b0, mant} + {23'd0, g & (r | s | mant[0])};
        if (mant_rnd[23]) begin
            rexp = rexp + 1;
        end
        return expect_word({1'b0, rexp[7:0], mant_rnd[22:0]}, 1'b0, 1'b0, g | r | s);
    endfunction

    task automatic send_operand(input logic [31:0] op, input logic [34:0] expected);
        @(negedge clk);
        in_valid = 1'b1;
        operand = op;
        expected_q.push_back(expected);
        // the DUT samples it at the coming rising edge
        strobe_q.push_back(cycle_count + 1);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clk);
            in_valid = 1'b0;
            operand = '0;
        end
    endtask

    task automatic send_directed(input logic [31:0] op, input logic [31:0] res,
                                 input logic inv, input logic dbz, input logic inx);
        send_operand(op, expect_word(res, inv, dbz, inx));
        idle_cycles(1);
    endtask

    task automatic draw_operand(input logic any_class, output logic [31:0] op);
        logic [31:0] r_exp;
        logic [31:0] r_mant;
        logic [7:0]  e;
        logic [22:0] m;
        int          kind;
        r_exp = $random(seed);
        r_mant = $random(seed);
        e = 8'(r_exp % 254 + 1);
        m = r_mant[22:0];
        kind = any_class ? int'($unsigned($random(seed)) % 8) : 7;
        case (kind)
            0: op = {r_mant[31], 8'h00, 23'd0};
            1: op = {r_mant[31], 8'h00, m | 23'd1};
            2: op = {r_mant[31], 8'hff, 23'd0};
            3: op = {r_mant[31], 8'hff, m | 23'h40_0000};
            4: op = {r_mant[31], 8'hff, (m & 23'h3f_ffff) | 23'd1};
            5: op = {1'b1, e, m};
            default: op = {1'b0, e, m};
        endcase
    endtask

    always @(negedge clk) begin : compare_outputs
        logic [34:0] expected;
        int          strobe_cycle;
        if (rst === 1'b0) begin
            if (out_valid === 1'b1) begin
                if (expected_q.size() == 0) begin
                    $display("out_valid at time %0t with no operand in flight", $time);
                    $display("Simulation finished: FAIL");
                    $fatal(1, "unexpected output strobe");
                end else begin
                    expected = expected_q.pop_front();
                    strobe_cycle = strobe_q.pop_front();
                    // the output is sampled at the next rising edge
                    check_value("latency", cycle_count + 1 - strobe_cycle, `RSQRT_LATENCY);
                    check_value("result", result, expected[34:3]);
                    check_value("invalid", {31'd0, invalid}, {31'd0, expected[2]});
                    check_value("division_by_zero", {31'd0, division_by_zero},
                                {31'd0, expected[1]});
                    check_value("inexact", {31'd0, inexact}, {31'd0, expected[0]});
                end
            end else begin
                // idle cycle, strobe and flags must be clean
                check_value("idle out_valid", {31'd0, out_valid}, 32'd0);
                check_value("idle flags", {29'd0, invalid, division_by_zero, inexact}, 32'd0);
            end
        end
    end

    initial begin : watchdog
        #(watchdog_cycles * clk_period);
        $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        logic [31:0] op;
        rst = 1'b1;
        in_valid = 1'b0;
        operand = '0;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("result after reset", result, 32'd0);

        // exact powers of four
        send_directed(32'h3F80_0000, 32'h3F80_0000, 1'b0, 1'b0, 1'b0);
        send_directed(32'h4080_0000, 32'h3F00_0000, 1'b0, 1'b0, 1'b0);
        send_directed(32'h4180_0000, 32'h3E80_0000, 1'b0, 1'b0, 1'b0);
        send_directed(32'h3E80_0000, 32'h4000_0000, 1'b0, 1'b0, 1'b0);
        send_directed(32'h0080_0000, 32'h5F00_0000, 1'b0, 1'b0, 1'b0);
        send_directed(32'h7E80_0000, 32'h2000_0000, 1'b0, 1'b0, 1'b0);

        // special operands
        send_directed(32'h7FC0_0001, 32'h7FC0_0001, 1'b0, 1'b0, 1'b0);
        send_directed(32'hFFC1_2345, 32'hFFC1_2345, 1'b0, 1'b0, 1'b0);
        send_directed(32'h7F80_0001, 32'h7FC0_0001, 1'b1, 1'b0, 1'b0);
        send_directed(32'hFF80_0005, 32'hFFC0_0005, 1'b1, 1'b0, 1'b0);
        send_directed(32'h0000_0000, 32'h7F80_0000, 1'b0, 1'b1, 1'b0);
        send_directed(32'h8000_0000, 32'hFF80_0000, 1'b0, 1'b1, 1'b0);
        send_directed(32'h0000_0001, 32'h7F80_0000, 1'b0, 1'b1, 1'b0);
        send_directed(32'h807F_FFFF, 32'hFF80_0000, 1'b0, 1'b1, 1'b0);
        send_directed(32'hBF80_0000, `RSQRT_QNAN, 1'b1, 1'b0, 1'b0);
        send_directed(32'hFF80_0000, `RSQRT_QNAN, 1'b1, 1'b0, 1'b0);
        send_directed(32'h7F80_0000, 32'h0000_0000, 1'b0, 1'b0, 1'b0);

        // positive normals on every cycle
        for (int i = 0; i < n_burst; i++) begin
            draw_operand(1'b0, op);
            send_operand(op, rsqrt_ref(op));
        end
        idle_cycles(1);

        // all classes, random gaps of zero to three cycles
        for (int i = 0; i < n_mixed; i++) begin
            draw_operand(1'b1, op);
            send_operand(op, rsqrt_ref(op));
            idle_cycles(int'($unsigned($random(seed)) % 4));
        end
        idle_cycles(1);

        while (expected_q.size() != 0) begin
            @(negedge clk);
        end
        // any extra strobe would show up here
        repeat (`RSQRT_LATENCY + 4) @(negedge clk);

        if (fp_rsqrt_top_i.fp_rsqrt_sva_i.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "assertions failed");
        end
    end

endmodule

// ==== tb.f ====
+incdir+include
hdl/rsqrt_pkg.sv
hdl/rsqrt_classify.sv
hdl/rsqrt_seed_lut.sv
hdl/mult_pipe.sv
hdl/newton_step.sv
hdl/rsqrt_round_pack.sv
hdl/fp_rsqrt_top.sv
test/fp_rsqrt_sva.sv
test/tb_fp_rsqrt.sv

// ==== Bender.yml ====
package:
  name: fp_rsqrt

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/rsqrt_pkg.sv
      - hdl/rsqrt_classify.sv
      - hdl/rsqrt_seed_lut.sv
      - hdl/mult_pipe.sv
      - hdl/newton_step.sv
      - hdl/rsqrt_round_pack.sv
      - hdl/fp_rsqrt_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/fp_rsqrt_sva.sv
      - test/tb_fp_rsqrt.sv
